// File: build.f
+incdir+logic
logic/rvPkg.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/aluStage.sv
logic/aluPipeCore.sv
testbench/aluPipeCore_chk.sv
testbench/aluPipeCore_tb.sv

// File: testbench/aluPipeCore_tb.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module aluPipeCore_tb import rvPkg::*; ();

  localparam int NUM_TESTS = 5;
  localparam int DRAIN_CYCLES = 6; // per test for the pipeline to empty

  // one table row with stimulus and what the model expects from it
  typedef struct packed {
    logic [`XLEN-1:0]       word;
    logic                   valid;
    logic [2:0]             testNum;
    logic                   expValid; // row should produce a commit
    logic [`REG_ADDR_W-1:0] expRd;
    logic [`XLEN-1:0]       expData;
  } stimRow_t;

  logic                   clk;
  logic                   rst;
  logic                   instrValid;
  logic [`XLEN-1:0]       instrWord;
  logic                   wbValid;
  logic [`REG_ADDR_W-1:0] wbAddr;
  logic [`XLEN-1:0]       wbData;
  logic [`XLEN-1:0]       dbgReg;

  stimRow_t         stimTable [$];
  logic [`XLEN-1:0] modelRegs [`REG_COUNT]; // reference register file
  logic [`XLEN-1:0] dbgExpect = '0;         // model x1 as the array holds it
  int seed        = 32'h233;
  int nextIdx     = 0;   // next table row owed a commit
  int curTest     = 1;
  int checkCount  = 0;
  int cycleCount  = 0;
  int cycleLimit  = 1000;
  int totalErrors = 0;
  int errCount  [1:NUM_TESTS] = '{default: 0};
  int seenCount [1:NUM_TESTS] = '{default: 0};
  int wantCount [1:NUM_TESTS] = '{default: 0};

  aluPipeCore UUT (
    .clk          (clk),
    .rst          (rst),
    .instrValid_i (instrValid),
    .instrWord_i  (instrWord),
    .wbValid_o    (wbValid),
    .wbAddr_o     (wbAddr),
    .wbData_o     (wbData),
    .dbgReg_o     (dbgReg)
  );

  always #20 clk = ~clk; // 40 ns period

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: run went past %0d cycles, commits still missing", cycleLimit);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [11:0] randImm();
    logic [31:0] v;
    v = $random(seed);
    return v[11:0];
  endfunction

  function automatic logic [`XLEN-1:0] rWord(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
    instrWord_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2[4:0];
    w.r.rs1    = rs1[4:0];
    w.r.funct3 = f3;
    w.r.rd     = rd[4:0];
    w.r.opcode = OPC_OP;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] iWord(input logic [11:0] imm, input logic [2:0] f3,
                                             input int rd, input int rs1);
    instrWord_u w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1[4:0];
    w.i.funct3 = f3;
    w.i.rd     = rd[4:0];
    w.i.opcode = OPC_OP_IMM;
    return w;
  endfunction

  // arithmetic shift built from a logical one plus a fill mask
  function automatic logic [`XLEN-1:0] shiftRightArith(input logic [`XLEN-1:0] a,
                                                       input logic [4:0] sh);
    logic [`XLEN-1:0] fill;
    fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
    return (a >> sh) | fill;
  endfunction

  // funct3 meaning with funct7 all zero for both R and I forms
  function automatic logic [`XLEN-1:0] baseOp(input logic [2:0] f3,
                                              input logic [`XLEN-1:0] a, b);
    logic [`XLEN-1:0] res;
    case (f3)
      3'b000:  res = a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = {{(`XLEN-1){1'b0}}, (a[31] != b[31]) ? a[31] : (a < b)}; // signed
      3'b011:  res = {{(`XLEN-1){1'b0}}, a < b};
      3'b100:  res = a ^ b;
      3'b101:  res = a >> b[4:0];
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // in-order reference step for one instruction and its modelRegs update
  function automatic void modelStep(input logic [`XLEN-1:0] raw, output logic commits,
                                    output logic [`REG_ADDR_W-1:0] rd,
                                    output logic [`XLEN-1:0] data);
    instrWord_u       w;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             known;
    w     = raw;
    a     = modelRegs[w.r.rs1];
    b     = modelRegs[w.r.rs2];
    rd    = w.r.rd;
    data  = '0;
    known = 1'b0;
    if (w.r.opcode == OPC_OP && w.r.funct7 == 7'b0000000) begin
      known = 1'b1;
      data  = baseOp(w.r.funct3, a, b);
    end else if (w.r.opcode == OPC_OP && w.r.funct7 == 7'b0100000) begin
      known = (w.r.funct3 == 3'b000) || (w.r.funct3 == 3'b101); // sub and sra only
      data  = (w.r.funct3 == 3'b000) ? a - b : shiftRightArith(a, b[4:0]);
    end else if (w.i.opcode == OPC_OP_IMM) begin
      b     = $signed(w.i.imm12); // widened by the signed cast
      known = w.i.funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
      data  = baseOp(w.i.funct3, a, b);
    end
    commits = known && rd != '0;
    if (commits) begin
      modelRegs[rd] = data;
    end
  endfunction

  task automatic issue(input logic [`XLEN-1:0] word, input int testNum);
    stimRow_t row;
    row.word    = word;
    row.valid   = 1'b1;
    row.testNum = testNum[2:0];
    modelStep(word, row.expValid, row.expRd, row.expData);
    stimTable.push_back(row);
    if (row.expValid) begin
      wantCount[testNum]++;
    end
  endtask

  // valid low with a real instruction left on the bus
  task automatic idleSlot(input logic [`XLEN-1:0] word, input int testNum);
    stimRow_t row;
    row = '{word: word, valid: 1'b0, testNum: testNum[2:0], expValid: 1'b0,
            expRd: '0, expData: '0};
    stimTable.push_back(row);
  endtask

  task automatic buildTable();
    // test 1 runs every op on random operands
    issue(iWord(randImm() | 12'h800, 3'b000, 5, 0), 1); // x5 negative
    issue(iWord(randImm() & 12'h7ff, 3'b000, 6, 0), 1); // x6 positive
    issue(iWord((randImm() & 12'h01f) | 12'h001, 3'b000, 7, 0), 1); // x7 nonzero shift
    issue(iWord(randImm(), 3'b000, 8, 0), 1);
    issue(rWord(7'h00, 3'b000, 9, 5, 6), 1);  // add
    issue(rWord(7'h20, 3'b000, 10, 5, 8), 1); // sub
    issue(rWord(7'h00, 3'b111, 11, 8, 5), 1); // and
    issue(rWord(7'h00, 3'b110, 12, 6, 8), 1); // or
    issue(rWord(7'h00, 3'b100, 13, 5, 8), 1); // xor
    issue(rWord(7'h00, 3'b001, 14, 8, 7), 1); // sll
    issue(rWord(7'h00, 3'b101, 15, 5, 7), 1); // srl of negative
    issue(rWord(7'h20, 3'b101, 16, 5, 7), 1); // sra of negative
    issue(rWord(7'h00, 3'b010, 17, 5, 6), 1); // slt neg < pos
    issue(rWord(7'h00, 3'b011, 18, 5, 6), 1); // sltu flips on the same pair
    issue(rWord(7'h00, 3'b010, 19, 6, 5), 1);
    issue(rWord(7'h00, 3'b011, 20, 6, 5), 1);
    issue(iWord(randImm(), 3'b000, 21, 5), 1); // addi
    issue(iWord(randImm(), 3'b111, 22, 8), 1); // andi
    issue(iWord(randImm(), 3'b110, 23, 6), 1); // ori
    issue(iWord(randImm(), 3'b100, 24, 5), 1); // xori
    issue(iWord(12'h7ff, 3'b010, 25, 5), 1);   // slti
    // test 2 covers dependency distance 1, 2 and 3
    issue(iWord(randImm(), 3'b000, 27, 0), 2);
    issue(rWord(7'h00, 3'b000, 28, 27, 27), 2); // both from execute
    issue(rWord(7'h20, 3'b000, 29, 28, 27), 2); // execute and writeback
    issue(iWord(randImm(), 3'b000, 30, 0), 2);
    issue(rWord(7'h00, 3'b110, 31, 9, 10), 2);
    issue(rWord(7'h00, 3'b100, 2, 30, 29), 2);  // x30 dist 2, x29 dist 3
    issue(rWord(7'h00, 3'b010, 3, 6, 2), 2);    // rs2 from execute
    // test 3 drops instructions
    issue(iWord(12'd123, 3'b000, 0, 5), 3);     // write to x0
    issue(rWord(7'h00, 3'b000, 0, 5, 6), 3);
    issue(rWord(7'h00, 3'b000, 9, 0, 0), 3);    // x0 right behind x0 writes
    issue(32'h0002a303, 3);                     // lw x6, 0(x5)
    issue(iWord(randImm(), 3'b011, 10, 5), 3);  // sltiu is unsupported
    issue(rWord(7'h01, 3'b000, 10, 5, 6), 3);   // mul encoding
    issue(rWord(7'h00, 3'b000, 13, 10, 0), 3);  // x10 must be untouched
    issue(rWord(7'h00, 3'b110, 11, 0, 6), 3);
    // test 4 puts idle gaps in the stream
    idleSlot(iWord(12'h555, 3'b000, 14, 0), 4);
    issue(iWord(randImm(), 3'b000, 14, 0), 4);
    idleSlot(rWord(7'h00, 3'b000, 15, 14, 14), 4);
    issue(iWord(12'd7, 3'b000, 15, 14), 4);
    idleSlot(iWord(12'h0aa, 3'b110, 16, 15), 4);
    idleSlot(iWord(12'h0aa, 3'b110, 16, 15), 4);
    issue(rWord(7'h00, 3'b000, 16, 15, 14), 4);
    issue(rWord(7'h20, 3'b000, 17, 16, 15), 4);
    // test 5 watches the x1 debug tap
    issue(iWord(randImm(), 3'b000, 1, 0), 5);
    issue(rWord(7'h00, 3'b000, 1, 1, 5), 5);
    idleSlot(iWord(12'h001, 3'b000, 1, 1), 5);
    issue(iWord(randImm(), 3'b100, 1, 1), 5);
    issue(rWord(7'h00, 3'b000, 18, 1, 1), 5);
  endtask

  // compare one observed commit with the next row that owes one
  task automatic checkCommit();
    stimRow_t row;
    while (nextIdx < stimTable.size() && !stimTable[nextIdx].expValid) begin
      nextIdx++;
    end
    assert (nextIdx < stimTable.size()) else begin
      $display("test %0d: commit to x%0d arrived when none was expected", curTest, wbAddr);
      errCount[curTest]++;
    end
    if (nextIdx < stimTable.size()) begin
      row = stimTable[nextIdx];
      nextIdx++;
      checkCount += 2;
      seenCount[row.testNum]++;
      assert (wbAddr == row.expRd) else begin
        $display("FAILED test %0d: wbAddr_o expected %h got %h", row.testNum, row.expRd, wbAddr);
        errCount[row.testNum]++;
      end
      assert (wbData == row.expData) else begin
        $display("FAILED test %0d: wbData_o expected %h got %h", row.testNum, row.expData,
                 wbData);
        errCount[row.testNum]++;
      end
      if (row.expRd == 1) begin
        dbgExpect = row.expData; // array holds it from the next edge on
      end
    end
  endtask

  // outputs only move on posedge so sample mid-cycle
  always @(negedge clk) begin
    checkCount++;
    assert (dbgReg == dbgExpect) else begin
      $display("FAILED test %0d: dbgReg_o expected %h got %h", curTest, dbgExpect, dbgReg);
      errCount[curTest]++;
    end
    if (wbValid === 1'b1) begin
      checkCommit();
    end
  end

  task automatic finishTest(input int t);
    @(negedge clk);
    instrValid = 1'b0;
    do begin
      @(posedge clk);
    end while (seenCount[t] < wantCount[t]);
    @(posedge clk); // last write reaches the array
    $display("test %0d: %0d of %0d commits seen, %0d errors", t, seenCount[t], wantCount[t],
             errCount[t]);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    instrValid = 1'b0;
    instrWord  = '0;
    for (int r = 0; r < `REG_COUNT; r++) begin
      modelRegs[r] = '0;
    end
    buildTable();
    cycleLimit = stimTable.size() + 20 + NUM_TESTS * DRAIN_CYCLES;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (stimTable[i]) begin
      if (stimTable[i].testNum != curTest) begin
        finishTest(curTest);
        curTest = stimTable[i].testNum;
      end
      @(negedge clk);
      instrValid = stimTable[i].valid;
      instrWord  = stimTable[i].word;
    end
    finishTest(curTest);
    repeat (2) @(negedge clk);
    for (int t = 1; t <= NUM_TESTS; t++) begin
      totalErrors += errCount[t];
    end
    totalErrors += UUT.uChk.violations; // bound assertion failures
    $display("summary: %0d checks, %0d errors", checkCount, totalErrors);
    if (totalErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: testbench/aluPipeCore_chk.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

// pipeline properties, bound into the core
module aluPipeCore_chk import rvPkg::*; (
  input logic                   clk,
  input logic                   rst,
  input idExBundle_t            idEx_i,    // decode to execute bundle
  input logic                   wbValid_i,
  input logic [`REG_ADDR_W-1:0] wbAddr_i
);

  int violations = 0; // summed into the testbench error count

  // commit strobe must be a clean 0 or 1 once out of reset
  wbValidKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(wbValid_i))
    else begin
      $error("wbValid_o is unknown");
      violations++;
    end

  // x0 writes are dropped in decode, never committed
  wbAddrNonZero: assert property (@(posedge clk) disable iff (rst) wbValid_i |-> wbAddr_i != '0)
    else begin
      $error("commit to x0 seen on wbAddr_o");
      violations++;
    end

  // execute always takes one cycle, no stalls
  idExToCommit: assert property (@(posedge clk) disable iff (rst) idEx_i.valid |=> wbValid_i)
    else begin
      $error("valid execute bundle produced no commit");
      violations++;
    end

endmodule

bind aluPipeCore aluPipeCore_chk uChk (
  .clk       (clk),
  .rst       (rst),
  .idEx_i    (idEx),
  .wbValid_i (wbValid_o),
  .wbAddr_i  (wbAddr_o)
);

// File: logic/aluPipeCore.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

// decode -> execute -> writeback, no stalls
module aluPipeCore import rvPkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   instrValid_i,
  input  logic [`XLEN-1:0]       instrWord_i,

  output logic                   wbValid_o,
  output logic [`REG_ADDR_W-1:0] wbAddr_o,
  output logic [`XLEN-1:0]       wbData_o,
  output logic [`XLEN-1:0]       dbgReg_o
);

  idExBundle_t            idEx;
  commitBundle_t          exFwd;   // execute result, bypass path
  commitBundle_t          commit;  // writeback
  logic                   re1;
  logic                   re2;
  logic [`REG_ADDR_W-1:0] raddr1;
  logic [`REG_ADDR_W-1:0] raddr2;
  logic [`XLEN-1:0]       rdata1;
  logic [`XLEN-1:0]       rdata2;

  instrDecoder uDecoder (
    .clk          (clk),
    .rst          (rst),
    .instrValid_i (instrValid_i),
    .instrWord_i  (instrWord_i),
    .exFwd_i      (exFwd),
    .re1_o        (re1),
    .raddr1_o     (raddr1),
    .re2_o        (re2),
    .raddr2_o     (raddr2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .idEx_o       (idEx)
  );

  aluStage uAlu (
    .clk      (clk),
    .rst      (rst),
    .idEx_i   (idEx),
    .exFwd_o  (exFwd),
    .commit_o (commit)
  );

  regFile uRegFile (
    .clk      (clk),
    .rst      (rst),
    .re1_i    (re1),
    .raddr1_i (raddr1),
    .rdata1_o (rdata1),
    .re2_i    (re2),
    .raddr2_i (raddr2),
    .rdata2_o (rdata2),
    .commit_i (commit),
    .dbgReg_o (dbgReg_o)
  );

  // commit record straight out
  assign wbValid_o = commit.valid;
  assign wbAddr_o  = commit.rd;
  assign wbData_o  = commit.data;

endmodule

// File: logic/aluStage.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

// execute stage, result goes out twice
// exFwd_o is the live result, commit_o the registered one
module aluStage import rvPkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  idExBundle_t   idEx_i,
  output commitBundle_t exFwd_o,  // to decoder bypass
  output commitBundle_t commit_o  // to regFile and core outputs
);

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [4:0]       shamt;      // rs2/imm low bits
  logic [`XLEN-1:0] aluResult;
  logic             validQ;
  commitBundle_t    commitQ;    // rd and data, valid from validQ

  assign opA   = idEx_i.operandA;
  assign opB   = idEx_i.operandB;
  assign shamt = opB[4:0];

  always_comb begin
    case (idEx_i.aluOp)
      ALU_ADD:  aluResult = opA + opB;
      ALU_SUB:  aluResult = opA - opB;
      ALU_AND:  aluResult = opA & opB;
      ALU_OR:   aluResult = opA | opB;
      ALU_XOR:  aluResult = opA ^ opB;
      ALU_SLL:  aluResult = opA << shamt;
      ALU_SRL:  aluResult = opA >> shamt;
      ALU_SRA:  aluResult = $unsigned($signed(opA) >>> shamt); // sign fill
      ALU_SLT: begin
        aluResult = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
      end
      ALU_SLTU: begin
        aluResult = {{(`XLEN-1){1'b0}}, (opA < opB)};
      end
      default:  aluResult = '0; // unused encodings
    endcase
  end

  // combinational copy for the decoder
  assign exFwd_o = '{valid: idEx_i.valid, rd: idEx_i.rd, data: aluResult};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      validQ <= 1'b0;
    end else begin
      validQ <= idEx_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    commitQ <= exFwd_o;
  end

  always_comb begin
    commit_o       = commitQ;
    commit_o.valid = validQ;
  end

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

// decode + operand fetch, registers the bundle for execute
module instrDecoder import rvPkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   instrValid_i,
  input  logic [`XLEN-1:0]       instrWord_i,
  input  commitBundle_t          exFwd_i,   // result now in execute

  output logic                   re1_o,
  output logic [`REG_ADDR_W-1:0] raddr1_o,
  output logic                   re2_o,
  output logic [`REG_ADDR_W-1:0] raddr2_o,
  input  logic [`XLEN-1:0]       rdata1_i,
  input  logic [`XLEN-1:0]       rdata2_i,

  output idExBundle_t            idEx_o
);

  instrWord_u       word;
  logic             isRType;
  logic             isIType;
  logic             opLegal;   // opcode and funct fields known
  aluOp_e           opSel;
  logic [`XLEN-1:0] immExt;
  logic [`XLEN-1:0] srcA;
  logic [`XLEN-1:0] srcB;
  logic             fwdA;
  logic             fwdB;
  logic             validD;
  logic             validQ;
  idExBundle_t      bundleD;
  idExBundle_t      bundleQ;   // payload only, valid kept in validQ

  assign word    = instrWord_i;
  assign isRType = (word.r.opcode == OPC_OP);
  assign isIType = (word.i.opcode == OPC_OP_IMM);

  // funct fields to alu op
  always_comb begin
    opSel   = ALU_ADD;
    opLegal = 1'b0;
    if (isRType) begin
      opLegal = 1'b1;
      case ({word.r.funct7, word.r.funct3})
        10'b0000000_000: opSel = ALU_ADD;
        10'b0100000_000: opSel = ALU_SUB;
        10'b0000000_001: opSel = ALU_SLL;
        10'b0000000_010: opSel = ALU_SLT;
        10'b0000000_011: opSel = ALU_SLTU;
        10'b0000000_100: opSel = ALU_XOR;
        10'b0000000_101: opSel = ALU_SRL;
        10'b0100000_101: opSel = ALU_SRA;
        10'b0000000_110: opSel = ALU_OR;
        10'b0000000_111: opSel = ALU_AND;
        default:         opLegal = 1'b0;
      endcase
    end else if (isIType) begin
      opLegal = 1'b1;
      case (word.i.funct3)
        3'b000:  opSel = ALU_ADD;  // addi
        3'b010:  opSel = ALU_SLT;  // slti
        3'b100:  opSel = ALU_XOR;  // xori
        3'b110:  opSel = ALU_OR;   // ori
        3'b111:  opSel = ALU_AND;  // andi
        default: opLegal = 1'b0;   // sltiu and shifts not supported
      endcase
    end
  end

  assign immExt = {{(`XLEN-12){word.i.imm12[11]}}, word.i.imm12};

  // regfile read requests, rs2 only for R form
  assign re1_o    = instrValid_i & (isRType | isIType);
  assign re2_o    = instrValid_i & isRType;
  assign raddr1_o = word.r.rs1;
  assign raddr2_o = word.r.rs2;

  // execute bypass, older writeback case handled inside regFile
  assign fwdA = re1_o && exFwd_i.valid && exFwd_i.rd == raddr1_o && raddr1_o != '0;
  assign fwdB = re2_o && exFwd_i.valid && exFwd_i.rd == raddr2_o && raddr2_o != '0;

  assign srcA = fwdA ? exFwd_i.data : rdata1_i;
  assign srcB = !isRType ? immExt : (fwdB ? exFwd_i.data : rdata2_i);

  // x0 destination or unknown encoding is dropped here
  assign validD  = instrValid_i & opLegal & (word.r.rd != '0);
  assign bundleD = '{valid: validD, aluOp: opSel, operandA: srcA,
                     operandB: srcB, rd: word.r.rd};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      validQ <= 1'b0;
    end else begin
      validQ <= validD;
    end
  end

  always_ff @(posedge clk) begin
    bundleQ <= bundleD;
  end

  always_comb begin
    idEx_o       = bundleQ;
    idEx_o.valid = validQ;
  end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

// 32 words, two async read ports, one clocked write port
// write data is forwarded to the read ports in the same cycle
module regFile import rvPkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   re1_i,    // port 1 enable
  input  logic [`REG_ADDR_W-1:0] raddr1_i,
  output logic [`XLEN-1:0]       rdata1_o,

  input  logic                   re2_i,    // port 2 enable
  input  logic [`REG_ADDR_W-1:0] raddr2_i,
  output logic [`XLEN-1:0]       rdata2_o,

  input  commitBundle_t          commit_i, // writeback
  output logic [`XLEN-1:0]       dbgReg_o  // x1 tap
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  assign dbgReg_o = regs[1];

  // one read port, shared by both
  function automatic logic [`XLEN-1:0] readPort(
    input logic                   en,
    input logic [`REG_ADDR_W-1:0] addr
  );
    logic [`XLEN-1:0] val;
    if (rst || !en) begin
      val = '0;                 // reset or disabled reads zero
    end else if (addr == '0) begin
      val = '0;                 // x0 hard-wired
    end else if (commit_i.valid && commit_i.rd == addr) begin
      val = commit_i.data;      // bypass from writeback
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rdata1_o = readPort(re1_i, raddr1_i);
  end

  always_comb begin
    rdata2_o = readPort(re2_i, raddr2_i);
  end

  // write on the edge after the commit is presented
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_i.valid && commit_i.rd != '0) begin
      regs[commit_i.rd] <= commit_i.data; // x0 never written
    end
  end

endmodule

// File: logic/rvPkg.sv
`include "rv_macros.svh"

package rvPkg;

  // major opcodes the core accepts
  localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate

  // R form of the instruction word, msb first
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } rTypeFields_t;

  // I form, rs2/funct7 slots become the immediate
  typedef struct packed {
    logic [11:0]            imm12;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } iTypeFields_t;

  // one word, two field layouts
  typedef union packed {
    rTypeFields_t r;
    iTypeFields_t i;
  } instrWord_u;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluOp_e;

  // decode to execute, operands already resolved
  typedef struct packed {
    logic                   valid;
    aluOp_e                 aluOp;
    logic [`XLEN-1:0]       operandA;
    logic [`XLEN-1:0]       operandB; // rs2 value or sign-extended imm
    logic [`REG_ADDR_W-1:0] rd;
  } idExBundle_t;

  // result record, also the regfile write port
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } commitBundle_t;

endpackage

// File: logic/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath word width, RV32I integer registers
`define XLEN 32

// architectural register count, x0 included
`define REG_COUNT 32

// bits needed to name one register
`define REG_ADDR_W 5

`endif
